// File: build.f
+incdir+design
design/rv_pkg.sv
design/rv_idu.sv
design/rv_exu.sv
design/rv_csr.sv
design/rv_fifo.sv
design/rv_regfile.sv
design/rv_exec_core.sv
verif/rv_exec_core_assert.sv
verif/tb_rv_exec_core.sv

// File: run.sh
#!/bin/sh
# build and run the execute core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
	--top-module tb_rv_exec_core -Mdir obj_dir -f build.f > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/Vtb_rv_exec_core > sim.log 2>&1
cat sim.log

grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0

// File: verif/tb_rv_exec_core.sv
`include "rv_macros.svh"

module tb_rv_exec_core import rv_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int K_LUI    = 0;
	localparam int K_ALUI   = 1;
	localparam int K_ALUR   = 2;
	localparam int K_BR     = 3;
	localparam int K_JAL    = 4;
	localparam int K_JALR   = 5;
	localparam int K_LW     = 6;
	localparam int K_SW     = 7;
	localparam int K_CSR    = 8;
	localparam int K_FENCEI = 9;

	typedef struct {
		int       kind;
		funct3_t  f3;
		bit       f7;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		word_t    imm;
		bit       rnd; // imm from the lfsr
		word_t    pc;
		word_t    dnpc;
	} entry_t;

	logic     clock;
	logic     rst_n;
	logic     inst_valid;
	word_t    inst;
	word_t    pc;
	word_t    dnpc;
	logic     wb_valid;
	reg_idx_t wb_rd;
	word_t    wb_data;
	logic     redirect_valid;
	word_t    redirect_target;
	logic     btb_wvalid;
	btb_pc_t  btb_pc;
	logic     lsu_ren;
	logic     lsu_wen;
	word_t    lsu_addr;

	entry_t    tbl[$];
	word_t     rf_model [`RV_NREG];
	word_t     csr_model [4];
	bit [15:0] lfsr_q = 16'd26916;
	int        cycle_count = 0;
	int        cycle_limit = 100000;

	rv_exec_core u_rv_exec_core (.*);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("run hung: %0d cycles without finishing", cycle_count);
			$display("TEST FAILED");
			$fatal(1, "timeout");
		end
	end

	function automatic word_t lfsr_bits(int n);
		word_t v;
		logic  fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
			lfsr_q = {lfsr_q[14:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic word_t alu_ref(funct3_t f3, bit sub, bit sra, word_t a, word_t b);
		case (f3)
			3'd0: return sub ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return word_t'($signed(a) < $signed(b));
			3'd3: return word_t'(a < b);
			3'd4: return a ^ b;
			3'd5: return sra ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic bit taken_ref(funct3_t f3, word_t a, word_t b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic word_t encode(entry_t e);
		case (e.kind)
			K_LUI:  return {e.imm[31:12], e.rd, 7'b0110111};
			K_ALUI: return {e.imm[11:0], e.rs1, e.f3, e.rd, 7'b0010011};
			K_ALUR: return {1'b0, e.f7, 5'b0, e.rs2, e.rs1, e.f3, e.rd, 7'b0110011};
			K_BR:   return {e.imm[12], e.imm[10:5], e.rs2, e.rs1, e.f3, e.imm[4:1],
				e.imm[11], 7'b1100011};
			K_JAL:  return {e.imm[20], e.imm[10:1], e.imm[11], e.imm[19:12], e.rd, 7'b1101111};
			K_JALR: return {e.imm[11:0], e.rs1, 3'b000, e.rd, 7'b1100111};
			K_LW:   return {e.imm[11:0], e.rs1, 3'b010, e.rd, 7'b0000011};
			K_SW:   return {e.imm[11:5], e.rs2, e.rs1, 3'b010, e.imm[4:0], 7'b0100011};
			K_CSR:  return {e.imm[11:0], e.rs1, e.f3, e.rd, 7'b1110011};
			default: return {17'b0, 3'b001, 5'b0, 7'b0001111}; // fence.i
		endcase
	endfunction

	task automatic add(int kind, funct3_t f3, bit f7, reg_idx_t rd, reg_idx_t rs1,
		reg_idx_t rs2, word_t imm, bit rnd, word_t epc, word_t ednpc);
		entry_t e;
		e = '{kind, f3, f7, rd, rs1, rs2, imm, rnd, epc, ednpc};
		tbl.push_back(e);
	endtask

	task automatic fail_now(string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_strobe(string name, bit exp, logic got);
		if (got !== exp)
			fail_now($sformatf("FAIL %s exp %h got %h", name, exp, got));
	endtask

	task automatic check_wb(reg_idx_t rd, word_t data);
		if (wb_rd !== rd)
			fail_now($sformatf("FAIL wb_rd exp %h got %h", rd, wb_rd));
		if (wb_data !== data)
			fail_now($sformatf("FAIL wb_data exp %h got %h", data, wb_data));
	endtask

	task automatic check_redirect(word_t target, btb_pc_t bpc, bit btb);
		if (redirect_target !== target)
			fail_now($sformatf("FAIL redirect_target exp %h got %h", target, redirect_target));
		if (btb_wvalid !== btb)
			fail_now($sformatf("FAIL btb_wvalid exp %h got %h", btb, btb_wvalid));
		if (btb && btb_pc !== bpc)
			fail_now($sformatf("FAIL btb_pc exp %h got %h", bpc, btb_pc));
	endtask

	task automatic check_lsu(word_t addr);
		if (lsu_addr !== addr)
			fail_now($sformatf("FAIL lsu_addr exp %h got %h", addr, lsu_addr));
	endtask

	task automatic run_entry(entry_t e);
		word_t a;
		word_t b;
		word_t val;
		word_t target;
		word_t old;
		bit    writes;
		bit    redir;
		bit    btb;
		if (e.rnd) begin
			e.imm = lfsr_bits(12);
			e.imm = {{20{e.imm[11]}}, e.imm[11:0]}; // sign-extended i-type field
		end
		a = rf_model[e.rs1];
		b = rf_model[e.rs2];
		target = e.pc + 4;
		writes = !(e.kind inside {K_BR, K_SW, K_FENCEI}) && e.rd != 0;
		val = '0;
		case (e.kind)
			K_LUI:  val = e.imm;
			K_ALUI: val = alu_ref(e.f3, 1'b0, e.imm[10], a, e.imm);
			K_ALUR: val = alu_ref(e.f3, e.f7, e.f7, a, b);
			K_BR:   if (taken_ref(e.f3, a, b)) target = e.pc + e.imm;
			K_JAL: begin
				val = e.pc + 4;
				target = e.pc + e.imm;
			end
			K_JALR: begin
				val = e.pc + 4;
				target = (a + e.imm) & ~32'd1;
			end
			K_LW, K_SW: val = a + e.imm; // loads write back the address
			K_CSR: begin
				old = csr_model[e.imm[1:0]];
				val = old;
				csr_model[e.imm[1:0]] = (e.f3 == 3'b001) ? a : (a | old);
			end
			default: ;
		endcase
		redir = (target != e.dnpc) || e.kind == K_FENCEI;
		btb = redir && ((e.kind == K_BR && e.imm[31]) || e.kind == K_JAL);
		if (writes)
			rf_model[e.rd] = val;

		@(posedge clock);
		#2;
		inst_valid = 1'b1;
		inst = encode(e);
		pc = e.pc;
		dnpc = e.dnpc;
		@(posedge clock);
		#2;
		inst_valid = 1'b0;
		@(posedge clock);
		@(negedge clock);
		check_strobe("lsu_ren", e.kind == K_LW, lsu_ren);
		check_strobe("lsu_wen", e.kind == K_SW, lsu_wen);
		if (e.kind inside {K_LW, K_SW})
			check_lsu(a + e.imm);
		@(posedge clock);
		@(negedge clock);
		check_strobe("wb_valid", writes, wb_valid);
		if (writes)
			check_wb(e.rd, val);
		check_strobe("redirect_valid", redir, redirect_valid);
		if (redir)
			check_redirect(target, e.pc[`RV_BTB_PC_W-1:0], btb);
		@(posedge clock);
	endtask

	initial begin
		rst_n = 1'b0;
		inst_valid = 1'b0;
		inst = '0;
		pc = '0;
		dnpc = '0;
		for (int i = 0; i < `RV_NREG; i++)
			rf_model[i] = '0;
		for (int i = 0; i < 4; i++)
			csr_model[i] = '0;

		add(K_LUI,  0, 0, 1, 0, 0, 32'h80000000, 0, 32'h100, 32'h104);
		add(K_LUI,  0, 0, 0, 0, 0, 32'h12345000, 0, 32'h100, 32'h104); // x0, no wb
		add(K_ALUI, 0, 0, 2, 0, 0, -5, 0, 32'h100, 32'h104);
		add(K_ALUI, 0, 0, 3, 0, 0, 0, 1, 32'h100, 32'h104);
		add(K_ALUI, 0, 0, 0, 2, 0, 7, 0, 32'h100, 32'h104);
		add(K_ALUR, 0, 0, 4, 1, 2, 0, 0, 32'h100, 32'h104);
		add(K_ALUR, 0, 1, 5, 2, 3, 0, 0, 32'h100, 32'h104);
		add(K_ALUI, 2, 0, 6, 2, 0, 1, 0, 32'h100, 32'h104);   // slti
		add(K_ALUI, 3, 0, 7, 2, 0, 1, 0, 32'h100, 32'h104);   // sltiu
		add(K_ALUI, 4, 0, 8, 3, 0, 0, 1, 32'h100, 32'h104);
		add(K_ALUI, 6, 0, 9, 3, 0, 0, 1, 32'h100, 32'h104);
		add(K_ALUI, 7, 0, 10, 3, 0, 0, 1, 32'h100, 32'h104);
		add(K_ALUI, 1, 0, 11, 2, 0, 4, 0, 32'h100, 32'h104);
		add(K_ALUI, 5, 0, 12, 1, 0, 3, 0, 32'h100, 32'h104);
		add(K_ALUI, 5, 0, 13, 1, 0, 32'h403, 0, 32'h100, 32'h104); // srai
		add(K_ALUR, 2, 0, 14, 1, 2, 0, 0, 32'h100, 32'h104);
		add(K_ALUR, 3, 0, 15, 1, 2, 0, 0, 32'h100, 32'h104);
		add(K_ALUR, 4, 0, 16, 1, 3, 0, 0, 32'h100, 32'h104);
		add(K_ALUR, 6, 0, 16, 2, 3, 0, 0, 32'h100, 32'h104);
		add(K_ALUR, 7, 0, 16, 2, 3, 0, 0, 32'h100, 32'h104);
		add(K_ALUR, 1, 0, 17, 2, 11, 0, 0, 32'h100, 32'h104);
		add(K_ALUR, 5, 0, 18, 2, 6, 0, 0, 32'h100, 32'h104);
		add(K_ALUR, 5, 1, 19, 2, 6, 0, 0, 32'h100, 32'h104);
		add(K_BR,   0, 0, 0, 2, 2, -16, 0, 32'h200, 32'h1f0);
		add(K_BR,   1, 0, 0, 1, 2, 32, 0, 32'h200, 32'h204);
		add(K_BR,   4, 0, 0, 1, 2, -8, 0, 32'h200, 32'h204);
		add(K_BR,   7, 0, 0, 1, 2, -8, 0, 32'h200, 32'h204);
		add(K_JAL,  0, 0, 20, 0, 0, 64, 0, 32'h300, 32'h340);
		add(K_JAL,  0, 0, 21, 0, 0, -32, 0, 32'h300, 32'h304);
		add(K_JALR, 0, 0, 22, 6, 0, 32'h101, 0, 32'h400, 32'h404);
		add(K_FENCEI, 0, 0, 0, 0, 0, 0, 0, 32'h500, 32'h504);
		add(K_LW,   0, 0, 23, 2, 0, 16, 0, 32'h100, 32'h104);
		add(K_SW,   0, 0, 0, 2, 3, 32, 0, 32'h100, 32'h104);
		add(K_CSR,  1, 0, 24, 1, 0, 1, 0, 32'h100, 32'h104);  // csrrw
		add(K_CSR,  2, 0, 25, 3, 0, 1, 0, 32'h100, 32'h104);  // csrrs
		add(K_CSR,  1, 0, 26, 0, 0, 1, 0, 32'h100, 32'h104);  // reads back the or

		cycle_limit = 10 + tbl.size() * 5 + 50;
		repeat (10) @(posedge clock);
		#2;
		rst_n = 1'b1;
		foreach (tbl[i])
			run_entry(tbl[i]);
		$display("TEST PASSED");
		$finish;
	end

endmodule

// File: verif/rv_exec_core_assert.sv
module rv_exec_core_assert import rv_pkg::*; (
	input logic clock,
	input logic rst_n,
	input logic wb_valid,
	input logic redirect_valid,
	input logic btb_wvalid,
	input logic lsu_ren,
	input logic lsu_wen,
	input logic exu_redirect,
	input logic exu_btb_update
);

	timeunit 1ns;
	timeprecision 1ps;

	// first cycle out of reset
	a_quiet_after_reset: assert property (@(posedge clock)
		$rose(rst_n) |-> !(wb_valid | redirect_valid | btb_wvalid | lsu_ren | lsu_wen))
		else $error("strobe high right after reset");

	// btb write comes from a backward redirect queued one cycle earlier
	a_btb_needs_redirect: assert property (@(posedge clock) disable iff (!rst_n)
		btb_wvalid |-> redirect_valid && $past(exu_redirect && exu_btb_update))
		else $error("btb_wvalid without a queued btb redirect");

endmodule

bind rv_exec_core rv_exec_core_assert u_exec_core_assert (.*);

// File: design/rv_exec_core.sv
module rv_exec_core import rv_pkg::*; (
	input  logic     clock,
	input  logic     rst_n,
	input  logic     inst_valid,
	input  word_t    inst,
	input  word_t    pc,
	input  word_t    dnpc,
	output logic     wb_valid,
	output reg_idx_t wb_rd,
	output word_t    wb_data,
	output logic     redirect_valid,
	output word_t    redirect_target,
	output logic     btb_wvalid,
	output btb_pc_t  btb_pc,
	output logic     lsu_ren,
	output logic     lsu_wen,
	output word_t    lsu_addr
);

	reg_idx_t      rf_raddr1;
	reg_idx_t      rf_raddr2;
	word_t         rf_rdata1;
	word_t         rf_rdata2;
	logic          dec_valid;
	opcode_class_t dec_class;
	reg_idx_t      dec_rd;
	word_t         dec_src1;
	word_t         dec_src2;
	word_t         dec_imm;
	funct3_t       dec_funct3;
	logic          dec_funct7_5;
	word_t         dec_pc;
	word_t         dec_dnpc;
	logic          dec_reg_wen;
	logic          dec_fencei;
	logic [1:0]    dec_csr_addr;
	word_t         csr_val;
	logic          exu_valid;
	reg_idx_t      exu_rd;
	word_t         exu_data;
	logic          exu_wen;
	logic          csr_wen;
	logic [1:0]    csr_waddr;
	word_t         csr_wdata;
	logic          exu_redirect;
	word_t         exu_target;
	btb_pc_t       exu_btb_pc;
	logic          exu_btb_update;
	wb_rec_t       wb_push_rec;
	wb_rec_t       wb_pop_rec;
	logic          wb_pop_valid;
	redirect_rec_t rr_push_rec;
	redirect_rec_t rr_pop_rec;

	assign wb_push_rec     = '{rd: exu_rd, data: exu_data, wen: exu_wen};
	assign rr_push_rec     = '{target: exu_target, btb_pc: exu_btb_pc, btb_update: exu_btb_update};
	assign redirect_target = rr_pop_rec.target;
	assign btb_pc          = rr_pop_rec.btb_pc;
	assign btb_wvalid      = redirect_valid & rr_pop_rec.btb_update;

	rv_idu u_idu (
		.clock(clock), .rst_n(rst_n), .inst_valid(inst_valid), .inst(inst),
		.pc(pc), .dnpc(dnpc), .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
		.rf_raddr1(rf_raddr1), .rf_raddr2(rf_raddr2), .dec_valid(dec_valid),
		.opcode_class(dec_class), .rd(dec_rd), .src1(dec_src1), .src2(dec_src2),
		.imm(dec_imm), .funct3(dec_funct3), .funct7_5(dec_funct7_5), .dec_pc(dec_pc),
		.dec_dnpc(dec_dnpc), .reg_wen(dec_reg_wen), .fencei(dec_fencei),
		.csr_addr(dec_csr_addr)
	);

	rv_exu u_exu (
		.clock(clock), .rst_n(rst_n), .dec_valid(dec_valid), .opcode_class(dec_class),
		.rd(dec_rd), .src1(dec_src1), .src2(dec_src2), .imm(dec_imm),
		.funct3(dec_funct3), .funct7_5(dec_funct7_5), .pc(dec_pc), .dnpc(dec_dnpc),
		.reg_wen(dec_reg_wen), .fencei(dec_fencei), .csr_addr(dec_csr_addr),
		.csr_val(csr_val), .exu_valid(exu_valid), .wb_rd(exu_rd), .wb_data(exu_data),
		.wb_wen(exu_wen), .csr_wen(csr_wen), .csr_waddr(csr_waddr), .csr_wdata(csr_wdata),
		.redirect_valid(exu_redirect), .redirect_target(exu_target), .btb_pc(exu_btb_pc),
		.btb_update(exu_btb_update), .lsu_ren(lsu_ren), .lsu_wen(lsu_wen),
		.lsu_addr(lsu_addr)
	);

	rv_csr u_csr (
		.clock(clock), .rst_n(rst_n), .raddr(dec_csr_addr), .wen(csr_wen),
		.waddr(csr_waddr), .wdata(csr_wdata), .rdata(csr_val)
	);

	rv_fifo #(.payload_t(wb_rec_t)) u_wb_q (
		.clock(clock), .rst_n(rst_n), .push(exu_valid), .push_data(wb_push_rec),
		.pop_valid(wb_pop_valid), .pop_data(wb_pop_rec)
	);

	rv_fifo #(.payload_t(redirect_rec_t)) u_redirect_q (
		.clock(clock), .rst_n(rst_n), .push(exu_redirect), .push_data(rr_push_rec),
		.pop_valid(redirect_valid), .pop_data(rr_pop_rec)
	);

	rv_regfile u_regfile (
		.clock(clock), .rst_n(rst_n), .raddr1(rf_raddr1), .raddr2(rf_raddr2),
		.wb_push(wb_pop_valid), .wb_rec(wb_pop_rec), .rdata1(rf_rdata1),
		.rdata2(rf_rdata2), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
	);

endmodule

// File: design/rv_regfile.sv
`include "rv_macros.svh"

module rv_regfile import rv_pkg::*; (
	input  logic     clock,
	input  logic     rst_n,
	input  reg_idx_t raddr1,
	input  reg_idx_t raddr2,
	input  logic     wb_push,
	input  wb_rec_t  wb_rec,
	output word_t    rdata1,
	output word_t    rdata2,
	output logic     wb_valid,
	output reg_idx_t wb_rd,
	output word_t    wb_data
);

	word_t regs [`RV_NREG];
	logic  do_write;

	assign do_write = wb_push & wb_rec.wen & (wb_rec.rd != 5'd0);

	// x0 is cleared at reset and never written
	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

	assign wb_valid = do_write; // same cycle as the array write
	assign wb_rd    = wb_rec.rd;
	assign wb_data  = wb_rec.data;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < `RV_NREG; i++) begin
				regs[i] <= '0;
			end
		end else if (do_write) begin
			regs[wb_rec.rd] <= wb_rec.data;
		end
	end

endmodule

// File: design/rv_fifo.sv
`include "rv_macros.svh"

module rv_fifo #(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     rst_n,
	input  logic     push,
	input  payload_t push_data,
	output logic     pop_valid,
	output payload_t pop_data
);

	localparam int DEPTH = `RV_Q_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	assign pop_valid = (count != '0); // drained every cycle
	assign pop_data  = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop_valid)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop_valid})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ; // push and pop cancel
			endcase
		end
	end

endmodule

// File: design/rv_csr.sv
module rv_csr import rv_pkg::*; (
	input  logic       clock,
	input  logic       rst_n,
	input  logic [1:0] raddr,
	input  logic       wen,
	input  logic [1:0] waddr,
	input  word_t      wdata,
	output word_t      rdata
);

	word_t csr_q [4]; // scratch registers

	assign rdata = csr_q[raddr]; // old value, seen by the execute stage

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < 4; i++) begin
				csr_q[i] <= '0;
			end
		end else if (wen) begin
			csr_q[waddr] <= wdata; // merged value from the execute stage
		end
	end

endmodule

// File: design/rv_exu.sv
`include "rv_macros.svh"

module rv_exu import rv_pkg::*; (
	input  logic          clock,
	input  logic          rst_n,
	input  logic          dec_valid,
	input  opcode_class_t opcode_class,
	input  reg_idx_t      rd,
	input  word_t         src1,
	input  word_t         src2,
	input  word_t         imm,
	input  funct3_t       funct3,
	input  logic          funct7_5,
	input  word_t         pc,
	input  word_t         dnpc,
	input  logic          reg_wen,
	input  logic          fencei,
	input  logic [1:0]    csr_addr,
	input  word_t         csr_val,
	output logic          exu_valid,
	output reg_idx_t      wb_rd,
	output word_t         wb_data,
	output logic          wb_wen,
	output logic          csr_wen,
	output logic [1:0]    csr_waddr,
	output word_t         csr_wdata,
	output logic          redirect_valid,
	output word_t         redirect_target,
	output btb_pc_t       btb_pc,
	output logic          btb_update,
	output logic          lsu_ren,
	output logic          lsu_wen,
	output word_t         lsu_addr
);

	word_t   loperand;
	word_t   roperand;
	word_t   alu_val;
	word_t   snpc;
	word_t   target;
	word_t   val;
	word_t   csr_wdata_c;
	alu_op_t alu_op;
	logic    br_cond;
	logic    jump_en;
	logic    csr_enable;
	logic    need_btb;
	logic    mispredict;

	assign snpc = pc + 32'd4;

	assign loperand = (opcode_class[`RV_INST_AUIPC] | opcode_class[`RV_INST_JAL]
		| opcode_class[`RV_INST_BEQ]) ? pc :
		opcode_class[`RV_INST_LUI] ? '0 : src1;
	assign roperand = opcode_class[`RV_INST_ADD] ? src2 : imm;

	always_comb begin
		alu_op = ALU_ADD; // address and upper-immediate sums
		if (opcode_class[`RV_INST_ADDI] | opcode_class[`RV_INST_ADD]) begin
			case (funct3)
				3'b000: alu_op = (opcode_class[`RV_INST_ADD] & funct7_5) ? ALU_SUB : ALU_ADD;
				3'b001: alu_op = ALU_SLL;
				3'b010: alu_op = ALU_LESS;
				3'b011: alu_op = ALU_ULESS;
				3'b100: alu_op = ALU_XOR;
				3'b101: alu_op = funct7_5 ? ALU_SRA : ALU_SRL;
				3'b110: alu_op = ALU_OR;
				default: alu_op = ALU_AND;
			endcase
		end
	end

	always_comb begin
		case (alu_op)
			ALU_SUB:   alu_val = loperand - roperand;
			ALU_AND:   alu_val = loperand & roperand;
			ALU_XOR:   alu_val = loperand ^ roperand;
			ALU_OR:    alu_val = loperand | roperand;
			ALU_SRL:   alu_val = loperand >> roperand[4:0];
			ALU_SRA:   alu_val = $signed(loperand) >>> roperand[4:0];
			ALU_SLL:   alu_val = loperand << roperand[4:0];
			ALU_LESS:  alu_val = word_t'($signed(loperand) < $signed(roperand));
			ALU_ULESS: alu_val = word_t'(loperand < roperand);
			default:   alu_val = loperand + roperand;
		endcase
	end

	// branch compare always on the two registers
	always_comb begin
		case (funct3)
			3'b000:  br_cond = (src1 == src2);
			3'b001:  br_cond = (src1 != src2);
			3'b100:  br_cond = $signed(src1) < $signed(src2);
			3'b101:  br_cond = $signed(src1) >= $signed(src2);
			3'b110:  br_cond = src1 < src2;
			3'b111:  br_cond = src1 >= src2;
			default: br_cond = 1'b0;
		endcase
	end

	assign jump_en = opcode_class[`RV_INST_JAL] | opcode_class[`RV_INST_JALR]
		| (opcode_class[`RV_INST_BEQ] & br_cond);
	assign target  = !jump_en ? snpc : // fence.i lands here too
		opcode_class[`RV_INST_JALR] ? {alu_val[31:1], 1'b0} : alu_val;

	assign mispredict = (target != dnpc) | fencei;
	assign need_btb   = (opcode_class[`RV_INST_BEQ] & imm[31]) | opcode_class[`RV_INST_JAL];

	assign csr_enable  = opcode_class[`RV_INST_CSR] & (funct3 != 3'b000);
	assign csr_wdata_c = (funct3 == 3'b010) ? (src1 | csr_val) : // csrrs
		(funct3 == 3'b001) ? src1 : '0;                           // csrrw

	assign val = (opcode_class[`RV_INST_JAL] | opcode_class[`RV_INST_JALR]) ? snpc :
		csr_enable ? csr_val : alu_val;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			exu_valid      <= 1'b0;
			csr_wen        <= 1'b0;
			redirect_valid <= 1'b0;
			lsu_ren        <= 1'b0;
			lsu_wen        <= 1'b0;
		end else begin
			exu_valid      <= dec_valid;
			csr_wen        <= dec_valid & csr_enable;
			redirect_valid <= dec_valid & mispredict;
			lsu_ren        <= dec_valid & opcode_class[`RV_INST_LW];
			lsu_wen        <= dec_valid & opcode_class[`RV_INST_SW];
		end
	end

	always_ff @(posedge clock) begin
		if (dec_valid) begin
			wb_rd           <= rd;
			wb_data         <= val;
			wb_wen          <= reg_wen;
			csr_waddr       <= csr_addr;
			csr_wdata       <= csr_wdata_c;
			redirect_target <= target;
			btb_pc          <= pc[`RV_BTB_PC_W-1:0];
			btb_update      <= need_btb;
			lsu_addr        <= alu_val; // src1 + imm
		end
	end

endmodule

// File: design/rv_idu.sv
`include "rv_macros.svh"

module rv_idu import rv_pkg::*; (
	input  logic          clock,
	input  logic          rst_n,
	input  logic          inst_valid,
	input  word_t         inst,
	input  word_t         pc,
	input  word_t         dnpc,
	input  word_t         rf_rdata1,
	input  word_t         rf_rdata2,
	output reg_idx_t      rf_raddr1,
	output reg_idx_t      rf_raddr2,
	output logic          dec_valid,
	output opcode_class_t opcode_class,
	output reg_idx_t      rd,
	output word_t         src1,
	output word_t         src2,
	output word_t         imm,
	output funct3_t       funct3,
	output logic          funct7_5,
	output word_t         dec_pc,
	output word_t         dec_dnpc,
	output logic          reg_wen,
	output logic          fencei,
	output logic [1:0]    csr_addr
);

	logic [6:0]    opcode;
	opcode_class_t class_c;
	word_t         imm_c;
	logic          wen_c;
	logic          fencei_c;

	assign opcode    = inst[6:0];
	assign rf_raddr1 = inst[19:15]; // rf answers in the same cycle
	assign rf_raddr2 = inst[24:20];

	always_comb begin
		class_c = '0;
		case (opcode)
			7'b0110111: class_c[`RV_INST_LUI]   = 1'b1;
			7'b0010111: class_c[`RV_INST_AUIPC] = 1'b1;
			7'b1101111: class_c[`RV_INST_JAL]   = 1'b1;
			7'b1100111: class_c[`RV_INST_JALR]  = 1'b1;
			7'b1100011: class_c[`RV_INST_BEQ]   = 1'b1;
			7'b0000011: class_c[`RV_INST_LW]    = 1'b1;
			7'b0100011: class_c[`RV_INST_SW]    = 1'b1;
			7'b0010011: class_c[`RV_INST_ADDI]  = 1'b1;
			7'b0110011: class_c[`RV_INST_ADD]   = 1'b1;
			7'b1110011: class_c[`RV_INST_CSR]   = 1'b1;
			default: ; // fence.i and unknown opcodes carry no class
		endcase
	end

	always_comb begin
		imm_c = {{20{inst[31]}}, inst[31:20]}; // i-type
		if (class_c[`RV_INST_SW])
			imm_c = {{20{inst[31]}}, inst[31:25], inst[11:7]};
		else if (class_c[`RV_INST_BEQ])
			imm_c = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
		else if (class_c[`RV_INST_LUI] | class_c[`RV_INST_AUIPC])
			imm_c = {inst[31:12], 12'b0};
		else if (class_c[`RV_INST_JAL])
			imm_c = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
	end

	assign fencei_c = (opcode == 7'b0001111) & (inst[14:12] == 3'b001);
	assign wen_c    = (|class_c) & ~class_c[`RV_INST_SW] & ~class_c[`RV_INST_BEQ]
		& (inst[11:7] != 5'd0); // x0 never written

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= inst_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (inst_valid) begin
			opcode_class <= class_c;
			rd           <= inst[11:7];
			src1         <= rf_rdata1;
			src2         <= rf_rdata2;
			imm          <= imm_c;
			funct3       <= inst[14:12];
			funct7_5     <= inst[30];
			dec_pc       <= pc;
			dec_dnpc     <= dnpc;
			reg_wen      <= wen_c;
			fencei       <= fencei_c;
			csr_addr     <= inst[21:20]; // four scratch csrs
		end
	end

endmodule

// File: design/rv_pkg.sv
`include "rv_macros.svh"

package rv_pkg;

	typedef logic [`RV_XLEN-1:0]     word_t;
	typedef logic [4:0]              reg_idx_t;
	typedef logic [2:0]              funct3_t;
	typedef logic [`RV_INST_CSR:0]   opcode_class_t; // one-hot
	typedef logic [`RV_BTB_PC_W-1:0] btb_pc_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_XOR,
		ALU_OR,
		ALU_SRL,
		ALU_SRA,
		ALU_SLL,
		ALU_LESS,
		ALU_ULESS
	} alu_op_t;

	typedef struct packed {
		reg_idx_t rd;
		word_t    data;
		logic     wen;
	} wb_rec_t;

	typedef struct packed {
		word_t   target;
		btb_pc_t btb_pc;
		logic    btb_update;
	} redirect_rec_t;

endpackage

// File: design/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// datapath widths
`define RV_XLEN      32
`define RV_BTB_PC_W  25 // low pc bits kept by the btb

// storage sizes
`define RV_NREG      32
`define RV_Q_DEPTH   4

// bit positions in the one-hot class vector
`define RV_INST_LUI   0
`define RV_INST_AUIPC 1
`define RV_INST_JAL   2
`define RV_INST_JALR  3
`define RV_INST_BEQ   4 // all conditional branches
`define RV_INST_LW    5
`define RV_INST_SW    6
`define RV_INST_ADDI  7 // register-immediate alu ops
`define RV_INST_ADD   8 // register-register alu ops
`define RV_INST_CSR   9

`endif
